// File: all.f
source/irq_pkg.sv
source/instr_pkg.sv
source/irq_arbiter.sv
source/irq_req_buffer.sv
source/wfi_sleep_ctrl.sv
source/irq_wfi_top.sv
sim/tb_irq_wfi.sv

// File: Makefile
# Verilator build and run of the interrupt front end testbench

SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := tb_irq_wfi
FILELIST := all.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := Test failures found
PASS_MSG := All tests passed!

SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides the result
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: sim/tb_irq_wfi.sv
// Testbench for the machine-mode interrupt front end
//   Clock, reset and watchdog
//   Stimulus table applied one row per clock, outputs checked a cycle later
//   Reference model for the pending word and the winning line

`default_nettype none

module tb_irq_wfi
  import irq_pkg::*;
  import instr_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED = 32'ha3e1_3a29;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 8;

  // Implemented lines 31..16, 11, 7 and 3
  localparam logic [31:0] IMPL_LINES = 32'hffff_0888;
  localparam logic [31:0] ALL = 32'hffff_ffff;
  localparam logic [31:0] NOP = 32'h0000_0013;

  // ------------------------------------------------
  // Row control bits
  // ------------------------------------------------
  localparam logic [8:0] MIE  = 9'h100;
  localparam logic [8:0] PM   = 9'h080;
  localparam logic [8:0] RDY  = 9'h040;
  localparam logic [8:0] RV   = 9'h020;
  localparam logic [8:0] ERR  = 9'h010;
  localparam logic [8:0] TW   = 9'h008;
  localparam logic [8:0] DM   = 9'h004;
  localparam logic [8:0] IDLE = 9'h002;
  localparam logic [8:0] DREQ = 9'h001;
  // M-mode with interrupts globally on
  localparam logic [8:0] EN   = MIE | PM;

  // Expected id codes other than a line number
  localparam int NONE  = -1;
  localparam int MODEL = -2;

  // Irq word source: literal, new random word, or last random word with random mie
  localparam int LIT  = 0;
  localparam int RND  = 1;
  localparam int SAME = 2;

  logic        clk_i;
  logic        rst_ni;
  irq_vec_t    irq_i;
  irq_vec_t    mie_i;
  logic        mstatus_mie_i;
  logic        mstatus_tw_i;
  priv_lvl_e   priv_lvl_i;
  irq_vec_t    mip_o;
  logic        irq_valid_o;
  irq_id_t     irq_id_o;
  logic        irq_ready_i;
  logic        retire_valid_i;
  logic [31:0] retire_instr_i;
  logic        retire_err_i;
  logic        debug_mode_i;
  logic        debug_req_i;
  logic        pipe_idle_i;
  logic        core_sleep_o;

  // Stimulus table, one entry per clock
  string       row_name[$];
  int          row_src[$];
  logic [31:0] row_irq[$];
  logic [31:0] row_mie[$];
  logic [8:0]  row_ctl[$];
  logic [31:0] row_instr[$];
  int          row_id[$];
  logic        row_sleep[$];

  int          n_rows = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  logic [31:0] last_rnd;
  logic [31:0] prev_mip;

  irq_wfi_top irq_wfi_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Winner from the priority rule: 31..16, then 11, 3, 7
  function automatic int pick_winner(logic [31:0] mip, logic [31:0] mie, logic [8:0] ctl);
    logic [31:0] pend;
    int          winner;
    pend   = mip & mie;
    winner = NONE;
    // Ascending scan, so the highest platform line is kept
    for (int k = 16; k < 32; k++) begin
      if (pend[k]) winner = k;
    end
    if (winner == NONE && pend[11]) winner = 11;
    if (winner == NONE && pend[3]) winner = 3;
    if (winner == NONE && pend[7]) winner = 7;
    // Global enable only matters in M-mode
    if ((|(ctl & PM)) && !(|(ctl & MIE))) winner = NONE;
    return winner;
  endfunction

  task automatic add_row(input string name, input int src, input logic [31:0] irq,
                         input logic [31:0] mie, input logic [8:0] ctl,
                         input logic [31:0] instr, input int exp_id, input logic exp_sleep);
    row_name.push_back(name);
    row_src.push_back(src);
    row_irq.push_back(irq);
    row_mie.push_back(mie);
    row_ctl.push_back(ctl);
    row_instr.push_back(instr);
    row_id.push_back(exp_id);
    row_sleep.push_back(exp_sleep);
  endtask

  task automatic apply_row(input int i);
    logic [31:0] irq_word;
    logic [31:0] mie_word;
    irq_word = row_irq[i];
    mie_word = row_mie[i];
    if (row_src[i] == RND) begin
      last_rnd = $urandom;
      irq_word = last_rnd;
    end else if (row_src[i] == SAME) begin
      irq_word = last_rnd;
      mie_word = $urandom;
    end
    irq_i          = irq_word;
    mie_i          = mie_word;
    mstatus_mie_i  = |(row_ctl[i] & MIE);
    priv_lvl_i     = (|(row_ctl[i] & PM)) ? PRIV_LVL_M : PRIV_LVL_U;
    irq_ready_i    = |(row_ctl[i] & RDY);
    retire_valid_i = |(row_ctl[i] & RV);
    retire_err_i   = |(row_ctl[i] & ERR);
    mstatus_tw_i   = |(row_ctl[i] & TW);
    debug_mode_i   = |(row_ctl[i] & DM);
    pipe_idle_i    = |(row_ctl[i] & IDLE);
    debug_req_i    = |(row_ctl[i] & DREQ);
    retire_instr_i = row_instr[i];
  endtask

  // Outputs after the clock edge that followed the row
  task automatic check_row(input int i);
    logic [31:0] exp_mip;
    int          exp_id;
    int          errs;
    errs    = 0;
    exp_mip = irq_i & IMPL_LINES;
    // The buffer loads from the pending word seen before the edge
    exp_id  = (row_id[i] == MODEL) ? pick_winner(prev_mip, mie_i, row_ctl[i]) : row_id[i];
    prev_mip = exp_mip;
    if (mip_o !== exp_mip) begin
      $display("FAIL t=%0t mip_o got %h exp %h", $time, mip_o, exp_mip);
      errs++;
    end
    if (irq_valid_o !== (exp_id != NONE)) begin
      $display("FAIL t=%0t irq_valid_o got %b exp %b", $time, irq_valid_o, exp_id != NONE);
      errs++;
    end else if (exp_id != NONE && irq_id_o !== irq_id_t'(exp_id)) begin
      $display("FAIL t=%0t irq_id_o got %0d exp %0d", $time, irq_id_o, exp_id);
      errs++;
    end
    if (core_sleep_o !== row_sleep[i]) begin
      $display("FAIL t=%0t core_sleep_o got %b exp %b", $time, core_sleep_o, row_sleep[i]);
      errs++;
    end
    if (errs == 0) begin
      n_pass++;
      $display("row %0d %s: pass", i, row_name[i]);
    end else begin
      n_fail++;
      $display("row %0d %s: %0d mismatches", i, row_name[i], errs);
    end
  endtask

  task automatic build_table();
    // ------------------------------------------------
    // Random pending words and winners
    // ------------------------------------------------
    for (int k = 0; k < 6; k++) begin
      add_row("rnd mip", RND, '0, '0, PM | RDY, NOP, NONE, 1'b0);
      add_row("rnd win", SAME, '0, '0, EN | RDY, NOP, MODEL, 1'b0);
      add_row("rnd ack", LIT, '0, '0, PM | RDY, NOP, NONE, 1'b0);
    end
    // ------------------------------------------------
    // Priority, masking, global enable
    // ------------------------------------------------
    // Odd rows set the lines and acknowledge, even rows expect the load
    add_row("prio 31", LIT, 32'h8000_0888, ALL, EN | RDY, NOP, NONE, 1'b0);
    add_row("prio 31", LIT, 32'h8000_0888, ALL, EN, NOP, 31, 1'b0);
    add_row("prio 17", LIT, 32'h0003_0888, ALL, EN | RDY, NOP, NONE, 1'b0);
    add_row("prio 17", LIT, 32'h0003_0888, ALL, EN, NOP, 17, 1'b0);
    add_row("prio 11", LIT, 32'h0000_0888, ALL, EN | RDY, NOP, NONE, 1'b0);
    add_row("prio 11", LIT, 32'h0000_0888, ALL, EN, NOP, 11, 1'b0);
    add_row("prio 3", LIT, 32'h0000_0088, ALL, EN | RDY, NOP, NONE, 1'b0);
    add_row("prio 3", LIT, 32'h0000_0088, ALL, EN, NOP, 3, 1'b0);
    add_row("prio 7", LIT, 32'h0000_0080, ALL, EN | RDY, NOP, NONE, 1'b0);
    add_row("prio 7", LIT, 32'h0000_0080, ALL, EN, NOP, 7, 1'b0);
    add_row("mie mask", LIT, 32'h0000_0888, 32'h0000_0080, EN | RDY, NOP, NONE, 1'b0);
    add_row("mie mask", LIT, 32'h0000_0888, 32'h0000_0080, EN, NOP, 7, 1'b0);
    add_row("mie off", LIT, 32'h0000_0888, ALL, PM | RDY, NOP, NONE, 1'b0);
    add_row("mie off", LIT, 32'h0000_0888, ALL, PM, NOP, NONE, 1'b0);
    add_row("u-mode", LIT, 32'h0000_0888, ALL, '0, NOP, 11, 1'b0);
    add_row("reserved", LIT, 32'h0000_f777, ALL, EN | RDY, NOP, NONE, 1'b0);
    // ------------------------------------------------
    // Handshake and back-pressure
    // ------------------------------------------------
    add_row("latency", LIT, 32'h0000_0080, ALL, EN, NOP, NONE, 1'b0);
    add_row("latency", LIT, 32'h0000_0080, ALL, EN, NOP, 7, 1'b0);
    add_row("hold", LIT, 32'h8000_0080, ALL, EN, NOP, 7, 1'b0);
    add_row("hold", LIT, 32'h8000_0080, ALL, EN, NOP, 7, 1'b0);
    add_row("ack gap", LIT, 32'h8000_0080, ALL, EN | RDY, NOP, NONE, 1'b0);
    add_row("reload", LIT, 32'h8000_0080, ALL, EN, NOP, 31, 1'b0);
    add_row("drain", LIT, '0, ALL, EN | RDY, NOP, NONE, 1'b0);
    add_row("drain", LIT, '0, ALL, EN, NOP, NONE, 1'b0);
    // ------------------------------------------------
    // Sleep entry and wake
    // ------------------------------------------------
    add_row("wfi", LIT, '0, ALL, EN | RV | IDLE, WFI_INSTR, NONE, 1'b0);
    add_row("wfi", LIT, '0, ALL, EN | IDLE, NOP, NONE, 1'b1);
    add_row("dbg wake", LIT, '0, ALL, EN | IDLE | DREQ, NOP, NONE, 1'b0);
    add_row("wfe busy", LIT, '0, ALL, EN | RV, WFE_INSTR, NONE, 1'b0);
    add_row("wfe busy", LIT, '0, ALL, EN, NOP, NONE, 1'b0);
    add_row("wfe busy", LIT, '0, ALL, EN, NOP, NONE, 1'b0);
    add_row("wfe idle", LIT, '0, ALL, EN | IDLE, NOP, NONE, 1'b1);
    // Global enable off, the enabled line still wakes the core
    add_row("irq wake", LIT, 32'h0000_0800, ALL, PM | IDLE, NOP, NONE, 1'b1);
    add_row("irq wake", LIT, 32'h0000_0800, ALL, PM | IDLE, NOP, NONE, 1'b0);
    add_row("irq wake", LIT, '0, ALL, PM | IDLE, NOP, NONE, 1'b0);
    // ------------------------------------------------
    // Retires that never sleep
    // ------------------------------------------------
    add_row("err", LIT, '0, ALL, PM | RV | ERR | IDLE, WFI_INSTR, NONE, 1'b0);
    add_row("err", LIT, '0, ALL, PM | IDLE, NOP, NONE, 1'b0);
    add_row("u tw", LIT, '0, ALL, RV | TW | IDLE, WFI_INSTR, NONE, 1'b0);
    add_row("u tw", LIT, '0, ALL, IDLE, NOP, NONE, 1'b0);
    add_row("dbg mode", LIT, '0, ALL, PM | RV | DM | IDLE, WFI_INSTR, NONE, 1'b0);
    add_row("dbg mode", LIT, '0, ALL, PM | IDLE, NOP, NONE, 1'b0);
    // TW has no effect in M-mode
    add_row("m tw", LIT, '0, ALL, PM | RV | TW | IDLE, WFE_INSTR, NONE, 1'b0);
    add_row("m tw", LIT, '0, ALL, PM | IDLE, NOP, NONE, 1'b1);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni         = 1'b0;
    irq_i          = '0;
    mie_i          = '0;
    mstatus_mie_i  = 1'b0;
    mstatus_tw_i   = 1'b0;
    priv_lvl_i     = PRIV_LVL_M;
    irq_ready_i    = 1'b0;
    retire_valid_i = 1'b0;
    retire_instr_i = '0;
    retire_err_i   = 1'b0;
    debug_mode_i   = 1'b0;
    debug_req_i    = 1'b0;
    pipe_idle_i    = 1'b0;
    prev_mip       = '0;
    build_table();
    n_rows = row_name.size();
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
      @(negedge clk_i);
      check_row(i);
    end
    $display("Summary: %0d rows passed, %0d rows failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog, 20 clock periods per table row
  initial begin
    wait (n_rows != 0);
    #(n_rows * 20 * CLK_PERIOD);
    $display("ERROR: watchdog expired before the table loop finished");
    $display("Test failures found");
    $finish;
  end

endmodule : tb_irq_wfi

`default_nettype wire

// File: source/irq_wfi_top.sv
// Machine-mode interrupt front end, top level
//   Arbiter feeding the one-entry request buffer
//   Sleep controller woken by the arbiter

`default_nettype none

module irq_wfi_top
  import irq_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_ni,

  // External interrupt lines and CSR state
  input  irq_vec_t     irq_i,
  input  irq_vec_t     mie_i,
  input  wire          mstatus_mie_i,
  input  wire          mstatus_tw_i,
  input  priv_lvl_e    priv_lvl_i,
  output irq_vec_t     mip_o,

  // Interrupt request to the core
  output logic         irq_valid_o,
  output irq_id_t      irq_id_o,
  input  wire          irq_ready_i,

  // Retire port
  input  wire          retire_valid_i,
  input  wire  [31:0]  retire_instr_i,
  input  wire          retire_err_i,

  // Debug and pipeline status
  input  wire          debug_mode_i,
  input  wire          debug_req_i,
  input  wire          pipe_idle_i,

  output logic         core_sleep_o
);

  // Arbiter results
  logic    win_valid;
  irq_id_t win_id;
  logic    wake_pending;

  // ------------------------------------------------
  // Request path
  // ------------------------------------------------

  irq_arbiter irq_arbiter_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .irq_i          (irq_i),
    .mie_i          (mie_i),
    .mstatus_mie_i  (mstatus_mie_i),
    .priv_lvl_i     (priv_lvl_i),
    .mip_o          (mip_o),
    .win_valid_o    (win_valid),
    .win_id_o       (win_id),
    .wake_pending_o (wake_pending)
  );

  irq_req_buffer irq_req_buffer_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .win_valid_i (win_valid),
    .win_id_i    (win_id),
    .irq_ready_i (irq_ready_i),
    .irq_valid_o (irq_valid_o),
    .irq_id_o    (irq_id_o)
  );

  // ------------------------------------------------
  // Sleep control
  // ------------------------------------------------

  wfi_sleep_ctrl wfi_sleep_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .retire_valid_i (retire_valid_i),
    .retire_instr_i (retire_instr_i),
    .retire_err_i   (retire_err_i),
    .priv_lvl_i     (priv_lvl_i),
    .mstatus_tw_i   (mstatus_tw_i),
    .debug_mode_i   (debug_mode_i),
    .debug_req_i    (debug_req_i),
    .pipe_idle_i    (pipe_idle_i),
    .wake_pending_i (wake_pending),
    .core_sleep_o   (core_sleep_o)
  );

endmodule : irq_wfi_top

`default_nettype wire

// File: source/wfi_sleep_ctrl.sv
// WFI/WFE sleep controller
//   Qualification of retiring wait instructions
//   Wait-state tracking with wake on interrupt or debug request
//   Registered core sleep output

`default_nettype none

module wfi_sleep_ctrl
  import irq_pkg::*;
  import instr_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_ni,

  // Retire port of the core
  input  wire          retire_valid_i,
  input  wire  [31:0]  retire_instr_i,
  input  wire          retire_err_i,

  // Status and control
  input  priv_lvl_e    priv_lvl_i,
  input  wire          mstatus_tw_i,
  input  wire          debug_mode_i,
  input  wire          debug_req_i,
  input  wire          pipe_idle_i,

  // Pending and enabled interrupt from the arbiter
  input  wire          wake_pending_i,

  output logic         core_sleep_o
);

  // One stage per cycle between the retire and the sleep flop
  logic [WFI_TO_SLEEP_LATENCY-2:0] wait_q;
  logic                            is_wait_instr;
  logic                            tw_trap;
  logic                            wait_retire;
  logic                            wake;
  logic                            sleep_q;

  // ------------------------------------------------
  // Retire qualification
  // ------------------------------------------------

  assign is_wait_instr = (retire_instr_i == WFI_INSTR) || (retire_instr_i == WFE_INSTR);

  // Timeout wait in U-mode turns the wait into an illegal instruction
  assign tw_trap = (priv_lvl_i == PRIV_LVL_U) && mstatus_tw_i;

  // Debug mode executes wait instructions as a nop
  assign wait_retire = retire_valid_i && is_wait_instr && !retire_err_i &&
                       !tw_trap && !debug_mode_i;

  // Any of these ends the wait
  assign wake = wake_pending_i || debug_req_i;

  // ------------------------------------------------
  // Wait state
  // ------------------------------------------------

  // Stage 0 is the wait state proper and holds until a wake event
  // A new retire wins over a wake in the same cycle, the wait then
  // lasts one cycle and sleep is never entered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= '0;
    end else begin
      wait_q[0] <= wait_retire || (wait_q[0] && !wake);
      for (int i = 1; i < WFI_TO_SLEEP_LATENCY - 1; i++) begin
        wait_q[i] <= wait_q[i-1] && !wake;
      end
    end
  end

  // ------------------------------------------------
  // Sleep output
  // ------------------------------------------------

  // Sleep only once the pipeline has drained
  // Stays low while an interrupt or debug request is present
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else begin
      sleep_q <= wait_q[WFI_TO_SLEEP_LATENCY-2] && pipe_idle_i && !wake;
    end
  end

  assign core_sleep_o = sleep_q;

endmodule : wfi_sleep_ctrl

`default_nettype wire

// File: source/irq_req_buffer.sv
// Interrupt request buffer
//   One-entry holding register between the arbiter and the core
//   Valid/ready handshake with back-pressure on the interrupt number

`default_nettype none

module irq_req_buffer
  import irq_pkg::*;
(
  input  wire      clk_i,
  input  wire      rst_ni,

  // Winner from the arbiter
  input  wire      win_valid_i,
  input  irq_id_t  win_id_i,

  // Core side
  input  wire      irq_ready_i,
  output logic     irq_valid_o,
  output irq_id_t  irq_id_o
);

  logic    full_q;
  irq_id_t id_q;
  logic    load;
  logic    xfer;

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------

  // Core takes the request
  assign xfer = full_q && irq_ready_i;

  // Only an empty slot is filled
  // The transfer cycle still sees full_q set, so no reload happens there
  // and valid drops for at least one cycle after each acknowledge
  assign load = win_valid_i && !full_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (xfer) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end
  end

  // Held number, frozen while waiting for ready
  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q <= win_id_i;
    end
  end

  assign irq_valid_o = full_q;
  assign irq_id_o    = id_q;

endmodule : irq_req_buffer

`default_nettype wire

// File: source/irq_arbiter.sv
// Interrupt arbiter
//   Pending register fed from the external lines, reserved lines dropped
//   Local and global enable masking
//   Fixed-priority pick of the winning line and the wake indication

`default_nettype none

module irq_arbiter
  import irq_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,

  // External lines and enables
  input  irq_vec_t   irq_i,
  input  irq_vec_t   mie_i,
  input  wire        mstatus_mie_i,
  input  priv_lvl_e  priv_lvl_i,

  // Pending word as seen by the CSR file
  output irq_vec_t   mip_o,

  // Winner towards the request buffer
  output logic       win_valid_o,
  output irq_id_t    win_id_o,

  // Any pending and enabled line, global enable ignored
  output logic       wake_pending_o
);

  // ------------------------------------------------
  // Pending register
  // ------------------------------------------------

  irq_vec_t mip_q;
  irq_vec_t pend_en;
  logic     global_en;
  logic     any_found;
  irq_id_t  sel_id;

  // Lines are sampled once per cycle
  // Reserved bits are cleared before the flop so they can never win
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign mip_o = mip_q;

  // ------------------------------------------------
  // Enable masking
  // ------------------------------------------------

  // Local enable per line
  assign pend_en = mip_q & mie_i;

  // M-mode honours mstatus.MIE
  // Lower privilege is always interruptible by M-mode interrupts
  assign global_en = (priv_lvl_i == PRIV_LVL_U) || mstatus_mie_i;

  // ------------------------------------------------
  // Fixed-priority selection
  // ------------------------------------------------

  // Order is 31 down to 16, then 11, then 3, then 7
  always_comb begin
    any_found = 1'b0;
    sel_id    = '0;

    // Platform lines, highest number first
    for (int i = NUM_IRQ - 1; i >= 16; i--) begin
      if (!any_found && pend_en[i]) begin
        any_found = 1'b1;
        sel_id    = irq_id_t'(i);
      end
    end

    // Machine external
    if (!any_found && pend_en[11]) begin
      any_found = 1'b1;
      sel_id    = irq_id_t'(11);
    end

    // Machine software beats machine timer
    if (!any_found && pend_en[3]) begin
      any_found = 1'b1;
      sel_id    = irq_id_t'(3);
    end

    if (!any_found && pend_en[7]) begin
      any_found = 1'b1;
      sel_id    = irq_id_t'(7);
    end
  end

  // A request is only offered when it may actually be taken
  assign win_valid_o = any_found && global_en;
  assign win_id_o    = sel_id;

  // Wakeup from WFI does not depend on the global enable
  assign wake_pending_o = any_found;

endmodule : irq_arbiter

`default_nettype wire

// File: source/instr_pkg.sv
// Instruction-side definitions for sleep control
//   Encodings of the two wait instructions
//   Cycles from a qualifying retire to the sleep output

`default_nettype none

package instr_pkg;

  // Wait for interrupt
  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;

  // Wait for event, custom encoding in the SYSTEM opcode space
  localparam logic [31:0] WFE_INSTR = 32'h8c00_0073;

  // Retire edge -> wait state set -> sleep output set
  // Must be 2 or more; the wait stage chain is this long minus one
  localparam int unsigned WFI_TO_SLEEP_LATENCY = 2;

endpackage : instr_pkg

`default_nettype wire

// File: source/irq_pkg.sv
// Interrupt-side definitions shared by the interrupt front end
//   Line count and implemented-line mask
//   Per-line vector type and interrupt number type
//   Privilege level encoding

`default_nettype none

package irq_pkg;

  // ------------------------------------------------
  // Interrupt lines
  // ------------------------------------------------

  // One bit per external interrupt line
  localparam int unsigned NUM_IRQ = 32;

  // Implemented lines 31..16 (platform), 11 (external), 7 (timer), 3 (software)
  // All other bits are reserved and never reach the pending word
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // Pending, enable and raw line words
  typedef logic [NUM_IRQ-1:0] irq_vec_t;

  // Number of the winning line, wide enough for any of the 32 lines
  typedef logic [$clog2(NUM_IRQ)-1:0] irq_id_t;

  // ------------------------------------------------
  // Privilege
  // ------------------------------------------------

  // Only user and machine mode exist on this core
  // Encodings follow the RISC-V privileged spec
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

endpackage : irq_pkg

`default_nettype wire
